// ==== hdl/rv_exec_pkg.sv ====
package rv_exec_pkg;

  // Program counter after reset unless the top level overrides it
  localparam logic [31:0] DEFAULT_RESET_PC = 32'h8000_0000;

  typedef enum logic [3:0] {
    ALU_IMM  = 4'd0,
    ALU_ADD  = 4'd1,
    ALU_SUB  = 4'd2,
    ALU_AND  = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_OR   = 4'd5,
    ALU_SLL  = 4'd6,
    ALU_SRL  = 4'd7,
    ALU_SRA  = 4'd8,
    ALU_SLT  = 4'd9,
    ALU_SLTU = 4'd10,
    ALU_SRC  = 4'd11
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE = 4'd0,
    BR_EQ   = 4'd1,
    BR_NE   = 4'd2,
    BR_LT   = 4'd3,
    BR_GE   = 4'd4,
    BR_LTU  = 4'd5,
    BR_GEU  = 4'd6,
    BR_JAL  = 4'd7,
    BR_JALR = 4'd8
  } br_op_e;

  typedef enum logic {
    WD_ALU = 1'b0,
    WD_PC4 = 1'b1
  } wd_sel_e;

  // RV32I major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

endpackage

// ==== hdl/alu.sv ====
module alu (
  input  logic [31:0]          src1,
  input  logic [31:0]          src2,
  input  rv_exec_pkg::alu_op_e alu_op,
  output logic [31:0]          result,
  output logic                 zero
);

  import rv_exec_pkg::*;

  logic [4:0] shamt;

  assign shamt = src2[4:0];

  always_comb begin
    case (alu_op)
      ALU_IMM:  result = src2;
      ALU_ADD:  result = src1 + src2;
      ALU_SUB:  result = src1 - src2;
      ALU_AND:  result = src1 & src2;
      ALU_XOR:  result = src1 ^ src2;
      ALU_OR:   result = src1 | src2;
      ALU_SLL:  result = src1 << shamt;
      ALU_SRL:  result = src1 >> shamt;
      ALU_SRA:  result = $unsigned($signed(src1) >>> shamt);
      ALU_SLT:  result = {31'd0, $signed(src1) < $signed(src2)};
      ALU_SLTU: result = {31'd0, src1 < src2};
      ALU_SRC:  result = src1;
      default:  result = 32'd0;
    endcase
  end

  // Only meaningful for add and subtract, used by BEQ/BNE
  assign zero = ((alu_op == ALU_ADD) || (alu_op == ALU_SUB)) && (result == 32'd0);

endmodule

// ==== hdl/regfile.sv ====
module regfile (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic        rf_we,
  input  logic [4:0]  rf_waddr,
  input  logic [31:0] rf_wdata
);

  // x0 has no storage
  logic [31:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (rf_we && (rf_waddr != 5'd0)) begin
      regs[rf_waddr] <= rf_wdata;
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

endmodule

// ==== hdl/idu.sv ====
module idu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_valid,
  input  logic [31:0]           inst,
  output logic                  inst_ready,
  input  logic                  exu_ready,
  input  logic [31:0]           cur_pc,
  input  logic                  retire_done,
  output logic [4:0]            rs1_addr,
  output logic [4:0]            rs2_addr,
  input  logic [31:0]           rs1_data,
  input  logic [31:0]           rs2_data,
  output logic                  idu_valid,
  output logic [31:0]           src1,
  output logic [31:0]           src2,
  output rv_exec_pkg::alu_op_e  alu_op,
  output rv_exec_pkg::br_op_e   br_op,
  output rv_exec_pkg::wd_sel_e  wd_sel,
  output logic [31:0]           imm,
  output logic [31:0]           pc,
  output logic [4:0]            rd,
  output logic                  reg_we
);

  import rv_exec_pkg::*;

  typedef enum logic {IDLE, BUSY} state_e;

  state_e      state;
  logic        accept;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [31:0] imm_i;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [31:0] imm_b;
  logic [31:0] d_src1;
  logic [31:0] d_src2;
  logic [31:0] d_imm;
  alu_op_e     d_alu_op;
  br_op_e      d_br_op;
  wd_sel_e     d_wd_sel;
  logic        d_writes;

  assign inst_ready = (state == IDLE);
  assign accept     = inst_valid && inst_ready;

  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'd0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt,
                                       input logic reg_form);
    case (f3)
      3'b000:  arith_op = (alt && reg_form) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  endfunction

  always_comb begin
    d_src1   = rs1_data;
    d_src2   = imm_i;
    d_imm    = imm_i;
    d_alu_op = ALU_IMM;
    d_br_op  = BR_NONE;
    d_wd_sel = WD_ALU;
    d_writes = 1'b0;
    case (opcode)
      OPC_LUI: begin
        d_src2   = imm_u;
        d_imm    = imm_u;
        d_writes = 1'b1;
      end
      OPC_AUIPC: begin
        d_src1   = cur_pc;
        d_src2   = imm_u;
        d_imm    = imm_u;
        d_alu_op = ALU_ADD;
        d_writes = 1'b1;
      end
      OPC_JAL: begin
        d_imm    = imm_j;
        d_alu_op = ALU_ADD;
        d_br_op  = BR_JAL;
        d_wd_sel = WD_PC4;
        d_writes = 1'b1;
      end
      OPC_JALR: begin
        d_alu_op = ALU_ADD;
        d_br_op  = BR_JALR;
        d_wd_sel = WD_PC4;
        d_writes = 1'b1;
      end
      OPC_BRANCH: begin
        d_src2 = rs2_data;
        d_imm  = imm_b;
        case (funct3)
          3'b000:  begin d_br_op = BR_EQ;  d_alu_op = ALU_SUB;  end
          3'b001:  begin d_br_op = BR_NE;  d_alu_op = ALU_SUB;  end
          3'b100:  begin d_br_op = BR_LT;  d_alu_op = ALU_SLT;  end
          3'b101:  begin d_br_op = BR_GE;  d_alu_op = ALU_SLT;  end
          3'b110:  begin d_br_op = BR_LTU; d_alu_op = ALU_SLTU; end
          3'b111:  begin d_br_op = BR_GEU; d_alu_op = ALU_SLTU; end
          default: d_br_op = BR_NONE;
        endcase
      end
      OPC_OPIMM: begin
        d_alu_op = arith_op(funct3, inst[30], 1'b0);
        d_writes = 1'b1;
      end
      OPC_OP: begin
        d_src2   = rs2_data;
        d_alu_op = arith_op(funct3, inst[30], 1'b1);
        d_writes = 1'b1;
      end
      default: d_writes = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      idu_valid <= 1'b0;
    end else begin
      if (accept) begin
        state     <= BUSY;
        idu_valid <= 1'b1;
      end else if (idu_valid && exu_ready) begin
        idu_valid <= 1'b0;
      end
      // Next instruction only after the current one has retired
      if (retire_done) begin
        state <= IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      src1   <= d_src1;
      src2   <= d_src2;
      alu_op <= d_alu_op;
      br_op  <= d_br_op;
      wd_sel <= d_wd_sel;
      imm    <= d_imm;
      pc     <= cur_pc;
      rd     <= inst[11:7];
      reg_we <= d_writes && (inst[11:7] != 5'd0);
    end
  end

endmodule

// ==== hdl/exu.sv ====
module exu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  idu_valid,
  output logic                  exu_ready,
  input  logic [31:0]           src1,
  input  logic [31:0]           src2,
  input  rv_exec_pkg::alu_op_e  alu_op,
  input  rv_exec_pkg::br_op_e   br_op,
  input  rv_exec_pkg::wd_sel_e  wd_sel,
  input  logic [31:0]           imm,
  input  logic [31:0]           pc,
  input  logic [4:0]            rd,
  input  logic                  reg_we,
  output logic                  exu_valid,
  input  logic                  wbu_ready,
  output rv_exec_pkg::br_op_e   ex_br_op,
  output rv_exec_pkg::wd_sel_e  ex_wd_sel,
  output logic [31:0]           ex_imm,
  output logic [31:0]           ex_pc,
  output logic [4:0]            ex_rd,
  output logic                  ex_reg_we,
  output logic [31:0]           alu_result,
  output logic                  zero
);

  import rv_exec_pkg::*;

  typedef enum logic {EMPTY, FULL} state_e;

  state_e      state;
  logic [31:0] ex_src1;
  logic [31:0] ex_src2;
  alu_op_e     ex_alu_op;
  logic        take;

  assign exu_ready = (state == EMPTY);
  assign exu_valid = (state == FULL);
  assign take      = idu_valid && exu_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= EMPTY;
    end else begin
      case (state)
        EMPTY: begin
          if (idu_valid) begin
            state <= FULL;
          end
        end
        FULL: begin
          // Held until writeback takes it
          if (wbu_ready) begin
            state <= EMPTY;
          end
        end
        default: state <= EMPTY;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      ex_src1   <= src1;
      ex_src2   <= src2;
      ex_alu_op <= alu_op;
      ex_br_op  <= br_op;
      ex_wd_sel <= wd_sel;
      ex_imm    <= imm;
      ex_pc     <= pc;
      ex_rd     <= rd;
      ex_reg_we <= reg_we;
    end
  end

  alu u_alu (
    .src1   (ex_src1),
    .src2   (ex_src2),
    .alu_op (ex_alu_op),
    .result (alu_result),
    .zero   (zero)
  );

endmodule

// ==== hdl/wbu.sv ====
module wbu #(
  parameter logic [31:0] RESET_PC = rv_exec_pkg::DEFAULT_RESET_PC
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  exu_valid,
  output logic                  wbu_ready,
  input  rv_exec_pkg::br_op_e   br_op,
  input  rv_exec_pkg::wd_sel_e  wd_sel,
  input  logic [31:0]           imm,
  input  logic [31:0]           pc,
  input  logic [4:0]            rd,
  input  logic                  reg_we,
  input  logic [31:0]           alu_result,
  input  logic                  zero,
  output logic                  rf_we,
  output logic [4:0]            rf_waddr,
  output logic [31:0]           rf_wdata,
  output logic [31:0]           cur_pc,
  output logic                  retire_valid,
  output logic [31:0]           retire_pc,
  output logic [4:0]            retire_rd,
  output logic [31:0]           retire_data,
  output logic                  retire_we,
  input  logic                  retire_ready,
  output logic                  retire_done
);

  import rv_exec_pkg::*;

  logic        accept;
  logic        taken;
  logic [31:0] pc4;
  logic [31:0] next_pc;
  logic [31:0] wdata;

  assign wbu_ready   = !retire_valid;
  assign accept      = exu_valid && wbu_ready;
  assign retire_done = retire_valid && retire_ready;

  // Compare results come as bit 0 of SLT/SLTU
  always_comb begin
    case (br_op)
      BR_EQ:   taken = zero;
      BR_NE:   taken = !zero;
      BR_LT:   taken = alu_result[0];
      BR_LTU:  taken = alu_result[0];
      BR_GE:   taken = !alu_result[0];
      BR_GEU:  taken = !alu_result[0];
      BR_JAL:  taken = 1'b1;
      BR_JALR: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign pc4 = pc + 32'd4;

  always_comb begin
    if (br_op == BR_JALR) begin
      next_pc = {alu_result[31:1], 1'b0};
    end else if (taken) begin
      next_pc = pc + imm;
    end else begin
      next_pc = pc4;
    end
  end

  assign wdata    = (wd_sel == WD_PC4) ? pc4 : alu_result;
  assign rf_we    = accept && reg_we;
  assign rf_waddr = rd;
  assign rf_wdata = wdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      cur_pc       <= RESET_PC;
      retire_valid <= 1'b0;
    end else if (accept) begin
      cur_pc       <= next_pc;
      retire_valid <= 1'b1;
    end else if (retire_done) begin
      retire_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      retire_pc   <= pc;
      retire_rd   <= rd;
      retire_data <= wdata;
      retire_we   <= reg_we;
    end
  end

endmodule

// ==== hdl/rv_exec_top.sv ====
module rv_exec_top #(
  parameter logic [31:0] RESET_PC = rv_exec_pkg::DEFAULT_RESET_PC
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        inst_valid,
  input  logic [31:0] inst,
  output logic        inst_ready,
  output logic [31:0] pc,
  output logic        retire_valid,
  output logic [31:0] retire_pc,
  output logic [4:0]  retire_rd,
  output logic [31:0] retire_data,
  output logic        retire_we,
  input  logic        retire_ready
);

  import rv_exec_pkg::*;

  logic        idu_valid;
  logic        exu_ready;
  logic        exu_valid;
  logic        wbu_ready;
  logic        retire_done;
  logic [4:0]  rs1_addr;
  logic [4:0]  rs2_addr;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic        rf_we;
  logic [4:0]  rf_waddr;
  logic [31:0] rf_wdata;

  // Decoded record
  logic [31:0] id_src1;
  logic [31:0] id_src2;
  alu_op_e     id_alu_op;
  br_op_e      id_br_op;
  wd_sel_e     id_wd_sel;
  logic [31:0] id_imm;
  logic [31:0] id_pc;
  logic [4:0]  id_rd;
  logic        id_reg_we;

  // Executed record
  br_op_e      ex_br_op;
  wd_sel_e     ex_wd_sel;
  logic [31:0] ex_imm;
  logic [31:0] ex_pc;
  logic [4:0]  ex_rd;
  logic        ex_reg_we;
  logic [31:0] alu_result;
  logic        zero;

  idu u_idu (
    .clk(clk), .rst(rst), .inst_valid(inst_valid), .inst(inst), .inst_ready(inst_ready),
    .exu_ready(exu_ready), .cur_pc(pc), .retire_done(retire_done),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .idu_valid(idu_valid), .src1(id_src1), .src2(id_src2), .alu_op(id_alu_op),
    .br_op(id_br_op), .wd_sel(id_wd_sel), .imm(id_imm), .pc(id_pc), .rd(id_rd),
    .reg_we(id_reg_we)
  );

  exu u_exu (
    .clk(clk), .rst(rst), .idu_valid(idu_valid), .exu_ready(exu_ready),
    .src1(id_src1), .src2(id_src2), .alu_op(id_alu_op), .br_op(id_br_op),
    .wd_sel(id_wd_sel), .imm(id_imm), .pc(id_pc), .rd(id_rd), .reg_we(id_reg_we),
    .exu_valid(exu_valid), .wbu_ready(wbu_ready), .ex_br_op(ex_br_op),
    .ex_wd_sel(ex_wd_sel), .ex_imm(ex_imm), .ex_pc(ex_pc), .ex_rd(ex_rd),
    .ex_reg_we(ex_reg_we), .alu_result(alu_result), .zero(zero)
  );

  wbu #(.RESET_PC(RESET_PC)) u_wbu (
    .clk(clk), .rst(rst), .exu_valid(exu_valid), .wbu_ready(wbu_ready),
    .br_op(ex_br_op), .wd_sel(ex_wd_sel), .imm(ex_imm), .pc(ex_pc), .rd(ex_rd),
    .reg_we(ex_reg_we), .alu_result(alu_result), .zero(zero),
    .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata), .cur_pc(pc),
    .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
    .retire_data(retire_data), .retire_we(retire_we), .retire_ready(retire_ready),
    .retire_done(retire_done)
  );

  regfile u_regfile (
    .clk(clk), .rst(rst), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .rf_we(rf_we), .rf_waddr(rf_waddr),
    .rf_wdata(rf_wdata)
  );

endmodule

// ==== verification/rv_exec_chk.sv ====
module rv_exec_chk (
  input logic        clk,
  input logic        rst,
  input logic        inst_ready,
  input logic        retire_valid,
  input logic        retire_ready,
  input logic [31:0] retire_pc,
  input logic [4:0]  retire_rd,
  input logic [31:0] retire_data,
  input logic        retire_we
);

  int fail_count = 0;

  // Fetch side waits for retire with one instruction in flight
  no_accept_during_retire: assert property (@(posedge clk) disable iff (rst)
    retire_valid |-> !inst_ready)
    else begin
      $error("inst_ready is high while a retire record is pending");
      fail_count++;
    end

  retire_record_held: assert property (@(posedge clk) disable iff (rst)
    retire_valid && !retire_ready |=> retire_valid && $stable(retire_pc)
      && $stable(retire_rd) && $stable(retire_data) && $stable(retire_we))
    else begin
      $error("retire record changed before it was accepted");
      fail_count++;
    end

  no_x0_write: assert property (@(posedge clk) disable iff (rst)
    retire_valid && retire_we |-> retire_rd != 5'd0)
    else begin
      $error("retire_we is high with retire_rd equal to x0");
      fail_count++;
    end

endmodule

bind rv_exec_top rv_exec_chk u_chk (
  .clk(clk), .rst(rst), .inst_ready(inst_ready), .retire_valid(retire_valid),
  .retire_ready(retire_ready), .retire_pc(retire_pc), .retire_rd(retire_rd),
  .retire_data(retire_data), .retire_we(retire_we)
);

// ==== verification/rv_exec_tb.sv ====
module rv_exec_tb;

  import rv_exec_pkg::*;

  localparam logic [31:0] RESET_PC   = 32'h8000_0000;
  localparam int          N_RETIRE   = 2000;
  localparam int          CLK_PERIOD = 8;

  logic        clk;
  logic        rst;
  logic        inst_valid;
  logic [31:0] inst;
  logic        inst_ready;
  logic [31:0] pc;
  logic        retire_valid;
  logic [31:0] retire_pc;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;
  logic        retire_we;
  logic        retire_ready;

  integer      seed;
  int          n_retired;
  logic        accepted;
  logic [31:0] model_regs [0:31];
  logic [31:0] model_pc;
  // Expected record of pc, rd, data, we and next pc
  logic [101:0] exp_q [$];

  rv_exec_top #(.RESET_PC(RESET_PC)) uut (
    .clk(clk), .rst(rst), .inst_valid(inst_valid), .inst(inst), .inst_ready(inst_ready),
    .pc(pc), .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
    .retire_data(retire_data), .retire_we(retire_we), .retire_ready(retire_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic report_mismatch(input string field, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("** Error at time %0t: %s is %h, expected %h", $time, field, got, exp);
    abort_run();
  endtask

  task automatic check_bound_assertions();
    assert (uut.u_chk.fail_count == 0) else begin
      $display("A handshake assertion in the bound checker failed");
      abort_run();
    end
  endtask

  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  function automatic logic [31:0] random_inst();
    logic [31:0] r;
    logic [31:0] s;
    logic [2:0]  f3;
    logic [6:0]  op;
    int          pick;
    r    = rand32();
    s    = rand32();
    pick = s[31:21] % 100;
    f3   = s[17:15];
    if (pick < 5) begin
      // Loads, stores, system and fence are outside the core
      case (s[20:19])
        2'd0:    op = 7'b0000011;
        2'd1:    op = 7'b0100011;
        2'd2:    op = 7'b1110011;
        default: op = 7'b0001111;
      endcase
      random_inst = {r[31:7], op};
    end else if (pick < 12) begin
      random_inst = {r[31:12], s[4:0], OPC_LUI};
    end else if (pick < 19) begin
      random_inst = {r[31:12], s[4:0], OPC_AUIPC};
    end else if (pick < 26) begin
      random_inst = {r[31:12], s[4:0], OPC_JAL};
    end else if (pick < 33) begin
      random_inst = {r[31:20], s[9:5], 3'b000, s[4:0], OPC_JALR};
    end else if (pick < 50) begin
      if (f3[2:1] == 2'b01) f3[2] = 1'b1;
      // Same source twice gives equal operands
      random_inst = {r[31:25], s[18] ? s[9:5] : s[14:10], s[9:5], f3, r[11:7], OPC_BRANCH};
    end else if (pick < 75) begin
      if (f3 == 3'b001) begin
        random_inst = {7'd0, r[24:20], s[9:5], f3, s[4:0], OPC_OPIMM};
      end else if (f3 == 3'b101) begin
        random_inst = {1'b0, s[20], 5'd0, r[24:20], s[9:5], f3, s[4:0], OPC_OPIMM};
      end else begin
        random_inst = {r[31:20], s[9:5], f3, s[4:0], OPC_OPIMM};
      end
    end else begin
      op = ((f3 == 3'b000 || f3 == 3'b101) && s[20]) ? 7'b0100000 : 7'd0;
      random_inst = {op, s[14:10], s[9:5], f3, s[4:0], OPC_OP};
    end
  endfunction

  function automatic logic [31:0] arith_model(input logic [2:0] f3, input logic alt,
      input logic reg_form, input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  arith_model = (alt && reg_form) ? a - b : a + b;
      3'b001:  arith_model = a << b[4:0];
      3'b010:  arith_model = {31'd0, $signed(a) < $signed(b)};
      3'b011:  arith_model = {31'd0, a < b};
      3'b100:  arith_model = a ^ b;
      3'b101: begin
        if (alt) arith_model = $signed(a) >>> b[4:0];
        else arith_model = a >> b[4:0];
      end
      3'b110:  arith_model = a | b;
      default: arith_model = a & b;
    endcase
  endfunction

  task automatic model_execute(input logic [31:0] w);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] res;
    logic [31:0] npc;
    logic        we;
    logic        taken;
    a     = model_regs[w[19:15]];
    b     = model_regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    res   = 32'd0;
    we    = 1'b0;
    taken = 1'b0;
    npc   = model_pc + 32'd4;
    case (w[6:0])
      OPC_LUI: begin
        res = {w[31:12], 12'd0};
        we  = 1'b1;
      end
      OPC_AUIPC: begin
        res = model_pc + {w[31:12], 12'd0};
        we  = 1'b1;
      end
      OPC_JAL: begin
        res = model_pc + 32'd4;
        we  = 1'b1;
        npc = model_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      OPC_JALR: begin
        res = model_pc + 32'd4;
        we  = 1'b1;
        npc = (a + imm_i) & ~32'd1;
      end
      OPC_BRANCH: begin
        case (w[14:12])
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = $signed(a) < $signed(b);
          3'b101:  taken = $signed(a) >= $signed(b);
          3'b110:  taken = a < b;
          3'b111:  taken = a >= b;
          default: taken = 1'b0;
        endcase
        if (taken) npc = model_pc + imm_b;
      end
      OPC_OPIMM: begin
        res = arith_model(w[14:12], w[30], 1'b0, a, imm_i);
        we  = 1'b1;
      end
      OPC_OP: begin
        res = arith_model(w[14:12], w[30], 1'b1, a, b);
        we  = 1'b1;
      end
      default:   we = 1'b0;
    endcase
    if (w[11:7] == 5'd0) we = 1'b0;
    exp_q.push_back({model_pc, w[11:7], res, we, npc});
    if (we) model_regs[w[11:7]] = res;
    model_pc = npc;
  endtask

  task automatic check_retire();
    logic [101:0] e;
    assert (exp_q.size() != 0) else begin
      $display("A retire record appeared with no instruction outstanding");
      abort_run();
    end
    e = exp_q.pop_front();
    assert (retire_pc == e[101:70]) else report_mismatch("retire_pc", retire_pc, e[101:70]);
    assert (retire_we == e[32]) else report_mismatch("retire_we", retire_we, e[32]);
    if (e[32]) begin
      assert (retire_rd == e[69:65]) else report_mismatch("retire_rd", retire_rd, e[69:65]);
      assert (retire_data == e[64:33]) else report_mismatch("retire_data", retire_data, e[64:33]);
    end
    assert (pc == e[31:0]) else report_mismatch("next pc", pc, e[31:0]);
    n_retired++;
  endtask

  initial begin
    logic [31:0] r;
    seed         = 32'hf2c3f210;
    rst          = 1'b1;
    inst_valid   = 1'b0;
    inst         = 32'd0;
    retire_ready = 1'b0;
    n_retired    = 0;
    model_pc     = RESET_PC;
    for (int i = 0; i < 32; i++) model_regs[i] = 32'd0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    assert (inst_ready && !retire_valid) else begin
      $display("DUT handshake outputs are wrong after reset");
      abort_run();
    end
    assert (pc == RESET_PC) else report_mismatch("pc after reset", pc, RESET_PC);
    while (n_retired < N_RETIRE) begin
      check_bound_assertions();
      // Handshakes decided at the falling edge with stable inputs
      accepted = inst_valid && inst_ready;
      if (accepted) begin
        assert (exp_q.size() == 0) else begin
          $display("An instruction was accepted while a retire was pending");
          abort_run();
        end
        assert (pc == model_pc) else report_mismatch("pc at accept", pc, model_pc);
        model_execute(inst);
      end
      if (retire_valid && retire_ready) check_retire();
      @(posedge clk);
      #1;
      // A waiting instruction is held until taken
      if (!(inst_valid && !accepted)) begin
        r          = rand32();
        inst_valid = (r % 4) != 0;
        inst       = random_inst();
      end
      r            = rand32();
      retire_ready = (r % 10) < 7;
      @(negedge clk);
    end
    check_bound_assertions();
    $display("*** TEST PASSED ***");
    $finish;
  end

  initial begin
    #(N_RETIRE * 40 * CLK_PERIOD);
    $display("Timeout: only %0d instructions retired", n_retired);
    abort_run();
  end

endmodule

// ==== rv_exec.f ====
hdl/rv_exec_pkg.sv
hdl/alu.sv
hdl/regfile.sv
hdl/idu.sv
hdl/exu.sv
hdl/wbu.sv
hdl/rv_exec_top.sv
verification/rv_exec_chk.sv
verification/rv_exec_tb.sv
